//--- verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;

    // ALU operation selectors
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;

    // Primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // SPECIAL function codes, inst[5:0]
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam int    NUM_REGS = 32;

endpackage

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            stall_i,
    input  mips_pkg::word_t if_data_i,
    output logic            if_ce_o,
    output mips_pkg::word_t if_addr_o,
    output mips_pkg::word_t id_pc_o,
    output mips_pkg::word_t id_inst_o
);
    import mips_pkg::*;

    word_t pc_q;

    // Fetch starts one cycle after reset release
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_ce_o <= 1'b0;
        end else begin
            if_ce_o <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (if_ce_o && !stall_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign if_addr_o = pc_q;

    // Zero word decodes as a no-op
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_pc_o   <= RESET_PC;
            id_inst_o <= '0;
        end else if (!stall_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= if_ce_o ? if_data_i : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  mips_pkg::word_t     id_inst_i,
    output mips_pkg::reg_addr_t rs_addr_o,
    output mips_pkg::reg_addr_t rt_addr_o,
    input  mips_pkg::word_t     rs_data_i,
    input  mips_pkg::word_t     rt_data_i,
    input  logic                ex_wreg_i,
    input  mips_pkg::reg_addr_t ex_wd_i,
    input  mips_pkg::word_t     ex_wdata_i,
    input  logic                ex_is_load_i,
    input  logic                mem_wreg_i,
    input  mips_pkg::reg_addr_t mem_wd_i,
    input  mips_pkg::word_t     mem_wdata_i,
    output mips_pkg::alu_op_t   alu_op_o,
    output mips_pkg::word_t     opa_o,
    output mips_pkg::word_t     opb_o,
    output mips_pkg::word_t     store_data_o,
    output logic                wreg_o,
    output mips_pkg::reg_addr_t wd_o,
    output logic                is_load_o,
    output logic                is_store_o,
    output logic                stall_o
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd;
    logic       rs_read;
    logic       rt_read;
    logic       use_imm;
    logic       zero_a;
    word_t      imm_ext;
    word_t      rs_val;
    word_t      rt_val;

    assign opcode    = id_inst_i[31:26];
    assign funct     = id_inst_i[5:0];
    assign rd        = id_inst_i[15:11];
    assign rs_addr_o = id_inst_i[25:21];
    assign rt_addr_o = id_inst_i[20:16];

    always_comb begin
        alu_op_o   = ALU_ADD;
        wreg_o     = 1'b0;
        wd_o       = rd;
        rs_read    = 1'b0;
        rt_read    = 1'b0;
        use_imm    = 1'b0;
        zero_a     = 1'b0;
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        imm_ext    = {{16{id_inst_i[15]}}, id_inst_i[15:0]};
        case (opcode)
            OP_SPECIAL: begin
                rs_read = 1'b1;
                rt_read = 1'b1;
                wreg_o  = 1'b1;
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    default: begin
                        // Unknown function code acts as a no-op
                        wreg_o  = 1'b0;
                        rs_read = 1'b0;
                        rt_read = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_LW, OP_SW: begin
                rs_read    = 1'b1;
                use_imm    = 1'b1;
                wd_o       = rt_addr_o;
                wreg_o     = (opcode != OP_SW);
                is_load_o  = (opcode == OP_LW);
                is_store_o = (opcode == OP_SW);
                rt_read    = (opcode == OP_SW);
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                rs_read  = 1'b1;
                use_imm  = 1'b1;
                wreg_o   = 1'b1;
                wd_o     = rt_addr_o;
                imm_ext  = {16'h0000, id_inst_i[15:0]};
                alu_op_o = (opcode == OP_ANDI) ? ALU_AND :
                           (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI: begin
                use_imm  = 1'b1;
                zero_a   = 1'b1;
                wreg_o   = 1'b1;
                wd_o     = rt_addr_o;
                alu_op_o = ALU_OR;
                imm_ext  = {id_inst_i[15:0], 16'h0000};
            end
            default: ;
        endcase
    end

    // Youngest producer wins, r0 never forwards
    assign rs_val = (ex_wreg_i && ex_wd_i == rs_addr_o && rs_addr_o != '0)   ? ex_wdata_i  :
                    (mem_wreg_i && mem_wd_i == rs_addr_o && rs_addr_o != '0) ? mem_wdata_i :
                    rs_data_i;
    assign rt_val = (ex_wreg_i && ex_wd_i == rt_addr_o && rt_addr_o != '0)   ? ex_wdata_i  :
                    (mem_wreg_i && mem_wd_i == rt_addr_o && rt_addr_o != '0) ? mem_wdata_i :
                    rt_data_i;

    assign opa_o        = zero_a ? '0 : rs_val;
    assign opb_o        = use_imm ? imm_ext : rt_val;
    assign store_data_o = rt_val;

    // Load result is not ready until the memory stage
    assign stall_o = ex_is_load_i && ex_wreg_i && ex_wd_i != '0 &&
                     ((rs_read && ex_wd_i == rs_addr_o) || (rt_read && ex_wd_i == rt_addr_o));

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t waddr_i,
    input  mips_pkg::word_t     wdata_i,
    input  mips_pkg::reg_addr_t raddr1_i,
    input  mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::word_t     rdata1_o,
    output mips_pkg::word_t     rdata2_o
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rdata1_o = (raddr1_i == '0)                   ? '0      :
                      (we_i && waddr_i == raddr1_i)      ? wdata_i :
                      regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)                   ? '0      :
                      (we_i && waddr_i == raddr2_i)      ? wdata_i :
                      regs[raddr2_i];

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                stall_i,
    input  mips_pkg::alu_op_t   alu_op_i,
    input  mips_pkg::word_t     opa_i,
    input  mips_pkg::word_t     opb_i,
    input  mips_pkg::word_t     store_data_i,
    input  logic                wreg_i,
    input  mips_pkg::reg_addr_t wd_i,
    input  logic                is_load_i,
    input  logic                is_store_i,
    output logic                ex_wreg_o,
    output mips_pkg::reg_addr_t ex_wd_o,
    output mips_pkg::word_t     ex_wdata_o,
    output logic                ex_is_load_o,
    output logic                mem_wreg_o,
    output mips_pkg::reg_addr_t mem_wd_o,
    output mips_pkg::word_t     mem_result_o,
    output mips_pkg::word_t     mem_store_data_o,
    output logic                mem_is_load_o,
    output logic                mem_is_store_o
);
    import mips_pkg::*;

    alu_op_t alu_op_q;
    word_t   opa_q;
    word_t   opb_q;
    word_t   store_data_q;
    logic    is_store_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_wreg_o    <= 1'b0;
            ex_is_load_o <= 1'b0;
            is_store_q   <= 1'b0;
        end else if (stall_i) begin
            // Stall inserts a bubble behind the load
            ex_wreg_o    <= 1'b0;
            ex_is_load_o <= 1'b0;
            is_store_q   <= 1'b0;
        end else begin
            ex_wreg_o    <= wreg_i;
            ex_is_load_o <= is_load_i;
            is_store_q   <= is_store_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_op_q     <= alu_op_i;
        opa_q        <= opa_i;
        opb_q        <= opb_i;
        store_data_q <= store_data_i;
        ex_wd_o      <= wd_i;
    end

    always_comb begin
        case (alu_op_q)
            ALU_ADD: ex_wdata_o = opa_q + opb_q;
            ALU_SUB: ex_wdata_o = opa_q - opb_q;
            ALU_AND: ex_wdata_o = opa_q & opb_q;
            ALU_OR:  ex_wdata_o = opa_q | opb_q;
            ALU_XOR: ex_wdata_o = opa_q ^ opb_q;
            ALU_SLT: ex_wdata_o = {31'd0, $signed(opa_q) < $signed(opb_q)};
            default: ex_wdata_o = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wreg_o     <= 1'b0;
            mem_is_load_o  <= 1'b0;
            mem_is_store_o <= 1'b0;
        end else begin
            mem_wreg_o     <= ex_wreg_o;
            mem_is_load_o  <= ex_is_load_o;
            mem_is_store_o <= is_store_q;
        end
    end

    always_ff @(posedge clk) begin
        mem_wd_o         <= ex_wd_o;
        mem_result_o     <= ex_wdata_o;
        mem_store_data_o <= store_data_q;
    end

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  logic                clk,
    input  logic                arst_n_i,
    input  mips_pkg::word_t     result_i,
    input  mips_pkg::word_t     store_data_i,
    input  logic                wreg_i,
    input  mips_pkg::reg_addr_t wd_i,
    input  logic                is_load_i,
    input  logic                is_store_i,
    input  mips_pkg::word_t     mem_data_i,
    output logic                mem_ce_o,
    output logic                mem_we_o,
    output mips_pkg::word_t     mem_addr_o,
    output mips_pkg::word_t     mem_data_o,
    output mips_pkg::word_t     fwd_wdata_o,
    output logic                wb_we_o,
    output mips_pkg::reg_addr_t wb_waddr_o,
    output mips_pkg::word_t     wb_wdata_o
);

    // ALU result doubles as the byte address
    assign mem_ce_o   = is_load_i | is_store_i;
    assign mem_we_o   = is_store_i;
    assign mem_addr_o = result_i;
    assign mem_data_o = store_data_i;

    assign fwd_wdata_o = is_load_i ? mem_data_i : result_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= wreg_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_waddr_o <= wd_i;
        wb_wdata_o <= fwd_wdata_o;
    end

endmodule

`default_nettype wire

//--- verilog/openmips.sv
`timescale 1ns/1ns
`default_nettype none

module openmips (
    input  logic            clk,
    input  logic            arst_n_i,
    input  mips_pkg::word_t if_data_i,
    output logic            if_ce_o,
    output mips_pkg::word_t if_addr_o,
    input  mips_pkg::word_t mem_data_i,
    output logic            mem_ce_o,
    output logic            mem_we_o,
    output mips_pkg::word_t mem_addr_o,
    output mips_pkg::word_t mem_data_o
);
    import mips_pkg::*;

    word_t     id_inst;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    logic      stall;

    // Decode to execute
    alu_op_t   id_alu_op;
    word_t     id_opa;
    word_t     id_opb;
    word_t     id_store_data;
    logic      id_wreg;
    reg_addr_t id_wd;
    logic      id_is_load;
    logic      id_is_store;

    // Execute outputs, also forwarded
    logic      ex_wreg;
    reg_addr_t ex_wd;
    word_t     ex_wdata;
    logic      ex_is_load;

    // Execute to memory
    logic      mem_wreg;
    reg_addr_t mem_wd;
    word_t     mem_result;
    word_t     mem_store_data;
    logic      mem_is_load;
    logic      mem_is_store;
    word_t     mem_fwd_wdata;

    // Write-back
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;

    fetch_stage fetch0 (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall),
        .if_data_i(if_data_i), .if_ce_o(if_ce_o), .if_addr_o(if_addr_o),
        .id_pc_o(), .id_inst_o(id_inst)
    );

    decode_stage decode0 (
        .id_inst_i(id_inst),
        .rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
        .rs_data_i(rs_data), .rt_data_i(rt_data),
        .ex_wreg_i(ex_wreg), .ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata),
        .ex_is_load_i(ex_is_load),
        .mem_wreg_i(mem_wreg), .mem_wd_i(mem_wd), .mem_wdata_i(mem_fwd_wdata),
        .alu_op_o(id_alu_op), .opa_o(id_opa), .opb_o(id_opb),
        .store_data_o(id_store_data), .wreg_o(id_wreg), .wd_o(id_wd),
        .is_load_o(id_is_load), .is_store_o(id_is_store), .stall_o(stall)
    );

    regfile regfile0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .we_i(wb_we), .waddr_i(wb_waddr), .wdata_i(wb_wdata),
        .raddr1_i(rs_addr), .raddr2_i(rt_addr),
        .rdata1_o(rs_data), .rdata2_o(rt_data)
    );

    execute_stage execute0 (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall),
        .alu_op_i(id_alu_op), .opa_i(id_opa), .opb_i(id_opb),
        .store_data_i(id_store_data), .wreg_i(id_wreg), .wd_i(id_wd),
        .is_load_i(id_is_load), .is_store_i(id_is_store),
        .ex_wreg_o(ex_wreg), .ex_wd_o(ex_wd), .ex_wdata_o(ex_wdata),
        .ex_is_load_o(ex_is_load),
        .mem_wreg_o(mem_wreg), .mem_wd_o(mem_wd), .mem_result_o(mem_result),
        .mem_store_data_o(mem_store_data),
        .mem_is_load_o(mem_is_load), .mem_is_store_o(mem_is_store)
    );

    mem_stage mem0 (
        .clk(clk), .arst_n_i(arst_n_i),
        .result_i(mem_result), .store_data_i(mem_store_data),
        .wreg_i(mem_wreg), .wd_i(mem_wd),
        .is_load_i(mem_is_load), .is_store_i(mem_is_store),
        .mem_data_i(mem_data_i),
        .mem_ce_o(mem_ce_o), .mem_we_o(mem_we_o),
        .mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o),
        .fwd_wdata_o(mem_fwd_wdata),
        .wb_we_o(wb_we), .wb_waddr_o(wb_waddr), .wb_wdata_o(wb_wdata)
    );

endmodule

`default_nettype wire

//--- bench/openmips_chk.sv
`timescale 1ns/1ns
`default_nettype none

module openmips_chk (
    input logic            clk,
    input logic            arst_n_i,
    input logic            if_ce_i,
    input mips_pkg::word_t if_addr_i,
    input logic            mem_ce_i,
    input logic            mem_we_i,
    input mips_pkg::word_t mem_addr_i
);

    // A write is always a chip-enabled cycle
    a_we_needs_ce: assert property (@(posedge clk) mem_we_i |-> mem_ce_i)
        else $error("mem_we_o high while mem_ce_o is low");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !(if_ce_i || mem_ce_i || mem_we_i))
        else $error("port enable active while in reset");

    a_if_addr_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        if_ce_i |-> !$isunknown(if_addr_i))
        else $error("if_addr_o unknown with if_ce_o high");

    a_mem_addr_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_ce_i |-> !$isunknown(mem_addr_i))
        else $error("mem_addr_o unknown with mem_ce_o high");

endmodule

bind openmips openmips_chk chk0 (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .if_ce_i(if_ce_o),
    .if_addr_i(if_addr_o),
    .mem_ce_i(mem_ce_o),
    .mem_we_i(mem_we_o),
    .mem_addr_i(mem_addr_o)
);

`default_nettype wire

//--- bench/tb_openmips.sv
`timescale 1ns/1ns
`default_nettype none

module tb_openmips;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          DRAIN_CYCLES = 20;
    localparam int          IMEM_DEPTH   = 1024;
    localparam int          DMEM_DEPTH   = 256;
    localparam int          NUM_RANDOM   = 6;
    localparam logic [31:0] SEED         = 32'h31fb;

    // Row operations
    localparam int OPC_ADDU  = 0;
    localparam int OPC_SUBU  = 1;
    localparam int OPC_AND   = 2;
    localparam int OPC_OR    = 3;
    localparam int OPC_XOR   = 4;
    localparam int OPC_SLT   = 5;
    localparam int OPC_ADDIU = 6;
    localparam int OPC_ANDI  = 7;
    localparam int OPC_ORI   = 8;
    localparam int OPC_XORI  = 9;
    localparam int OPC_LUI   = 10;
    localparam int NUM_OPS   = 11;

    logic        clk;
    logic        arst_n;
    logic [31:0] if_data;
    logic        if_ce;
    logic [31:0] if_addr;
    logic [31:0] mem_rdata;
    logic        mem_ce;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;

    logic [31:0] imem [IMEM_DEPTH];
    logic [31:0] dmem [DMEM_DEPTH];
    logic [9:0]  fill_ptr;

    int          op_tab[$];
    logic [31:0] a_tab[$];
    logic [31:0] b_tab[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    int          prog_len = 0;
    int          n_stores = 0;
    int          n_checks = 0;
    int          n_errors = 0;

    openmips DUT (
        .clk(clk),
        .arst_n_i(arst_n),
        .if_data_i(if_data),
        .if_ce_o(if_ce),
        .if_addr_o(if_addr),
        .mem_data_i(mem_rdata),
        .mem_ce_o(mem_ce),
        .mem_we_o(mem_we),
        .mem_addr_o(mem_addr),
        .mem_data_o(mem_wdata)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Single-cycle memories
    assign if_data   = if_ce ? imem[if_addr[11:2]] : 32'h0;
    assign mem_rdata = mem_ce ? dmem[mem_addr[9:2]] : 32'h0;

    always @(posedge clk) begin
        if (mem_ce && mem_we) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    // Stores must match the expected list in program order
    always @(negedge clk) begin
        if (mem_ce && mem_we) begin
            n_checks++;
            if (n_stores >= exp_addr.size()) begin
                n_errors++;
                $display("FAILED at %0t ns: extra store of %h to %h", $time, mem_wdata, mem_addr);
            end else if (mem_addr !== exp_addr[n_stores] || mem_wdata !== exp_data[n_stores]) begin
                n_errors++;
                $display("FAILED at %0t ns: store %0d wrote %h to %h, expected %h to %h",
                         $time, n_stores, mem_wdata, mem_addr,
                         exp_data[n_stores], exp_addr[n_stores]);
            end
            n_stores++;
        end
    end

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    // r3 from r1 and r2 or from r1 and the immediate
    function automatic logic [31:0] encode_row_op(input int op, input logic [15:0] imm);
        case (op)
            OPC_ADDU:  return r_type(6'h21, 5'd3, 5'd1, 5'd2);
            OPC_SUBU:  return r_type(6'h23, 5'd3, 5'd1, 5'd2);
            OPC_AND:   return r_type(6'h24, 5'd3, 5'd1, 5'd2);
            OPC_OR:    return r_type(6'h25, 5'd3, 5'd1, 5'd2);
            OPC_XOR:   return r_type(6'h26, 5'd3, 5'd1, 5'd2);
            OPC_SLT:   return r_type(6'h2a, 5'd3, 5'd1, 5'd2);
            OPC_ADDIU: return i_type(6'h09, 5'd1, 5'd3, imm);
            OPC_ANDI:  return i_type(6'h0c, 5'd1, 5'd3, imm);
            OPC_ORI:   return i_type(6'h0d, 5'd1, 5'd3, imm);
            OPC_XORI:  return i_type(6'h0e, 5'd1, 5'd3, imm);
            OPC_LUI:   return i_type(6'h0f, 5'd0, 5'd3, imm);
            default:   return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] model_op(input int op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            OPC_ADDU:  return a + b;
            OPC_SUBU:  return a - b;
            OPC_AND:   return a & b;
            OPC_OR:    return a | b;
            OPC_XOR:   return a ^ b;
            OPC_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OPC_ADDIU: return a + {{16{b[15]}}, b[15:0]};
            OPC_ANDI:  return a & {16'h0000, b[15:0]};
            OPC_ORI:   return a | {16'h0000, b[15:0]};
            OPC_XORI:  return a ^ {16'h0000, b[15:0]};
            OPC_LUI:   return {b[15:0], 16'h0000};
            default:   return 32'h0;
        endcase
    endfunction

    task automatic add_row(input int op, input logic [31:0] a, input logic [31:0] b);
        op_tab.push_back(op);
        a_tab.push_back(a);
        b_tab.push_back(b);
    endtask

    task automatic put(input logic [31:0] inst);
        imem[fill_ptr] = inst;
        fill_ptr = fill_ptr + 10'd1;
    endtask

    task automatic build_constant(input logic [4:0] rd, input logic [31:0] value);
        put(i_type(6'h0f, 5'd0, rd, value[31:16]));
        put(i_type(6'h0d, rd, rd, value[15:0]));
    endtask

    task automatic build_program();
        fill_ptr = '0;
        imem = '{default: 32'h0};
        for (int row = 0; row < op_tab.size(); row++) begin
            build_constant(5'd1, a_tab[row]);
            build_constant(5'd2, b_tab[row]);
            put(encode_row_op(op_tab[row], b_tab[row][15:0]));
            put(i_type(6'h2b, 5'd0, 5'd3, 16'(row * 4)));
            exp_addr.push_back(32'(row * 4));
            exp_data.push_back(model_op(op_tab[row], a_tab[row], b_tab[row]));
        end
        // Load-use pair on row 0 and a write to r0
        put(i_type(6'h23, 5'd0, 5'd4, 16'h0000));
        put(r_type(6'h21, 5'd5, 5'd4, 5'd4));
        put(i_type(6'h2b, 5'd0, 5'd5, 16'(op_tab.size() * 4)));
        exp_addr.push_back(32'(op_tab.size() * 4));
        exp_data.push_back(exp_data[0] + exp_data[0]);
        put(i_type(6'h09, 5'd0, 5'd0, 16'h7777));
        put(i_type(6'h2b, 5'd0, 5'd0, 16'(op_tab.size() * 4 + 4)));
        exp_addr.push_back(32'(op_tab.size() * 4 + 4));
        exp_data.push_back(32'h0);
        prog_len = int'(fill_ptr);
    endtask

    initial begin
        int          op;
        logic [31:0] a;
        logic [31:0] b;
        arst_n = 1'b1;
        void'($urandom(SEED));
        // Corner rows with row 0 feeding the load
        add_row(OPC_XOR,   32'hFFFF_FFFF, 32'h5555_AAAA);
        add_row(OPC_ADDU,  32'hFFFF_FFFF, 32'h0000_0001);
        add_row(OPC_SUBU,  32'h0000_0000, 32'h0000_0001);
        add_row(OPC_AND,   32'hFFFF_FFFF, 32'h8000_0000);
        add_row(OPC_OR,    32'h0000_0000, 32'h7FFF_FFFF);
        add_row(OPC_SLT,   32'h8000_0000, 32'h7FFF_FFFF);
        add_row(OPC_SLT,   32'h7FFF_FFFF, 32'h8000_0000);
        add_row(OPC_ADDIU, 32'h0000_0010, 32'h0000_FFF0);
        add_row(OPC_ANDI,  32'hFFFF_FFFF, 32'h0000_8000);
        add_row(OPC_ORI,   32'h8000_0000, 32'h0000_FFFF);
        add_row(OPC_XORI,  32'hFFFF_FFFF, 32'h0000_8001);
        add_row(OPC_LUI,   32'h0000_0000, 32'h0000_8001);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op = $urandom % NUM_OPS;
            a = $urandom;
            b = $urandom;
            add_row(op, a, b);
        end
        build_program();

        #1 arst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            n_checks++;
            if (if_ce || mem_ce || mem_we) begin
                n_errors++;
                $display("FAILED at %0t ns: port enable active during reset", $time);
            end
        end
        arst_n = 1'b1;
        @(negedge clk);
        n_checks++;
        if (if_ce || mem_ce || mem_we) begin
            n_errors++;
            $display("FAILED at %0t ns: port enable active at reset release", $time);
        end
        @(posedge clk);
        #1;
        n_checks++;
        if (!if_ce || if_addr !== 32'h0) begin
            n_errors++;
            $display("FAILED at %0t ns: first fetch ce=%b addr=%h, expected ce=1 addr=0",
                     $time, if_ce, if_addr);
        end

        while (n_stores < exp_addr.size()) begin
            @(posedge clk);
        end
        // Let the nop tail run to catch stray stores
        repeat (DRAIN_CYCLES) @(posedge clk);
        n_checks++;
        if (n_stores != exp_addr.size()) begin
            n_errors++;
            $display("FAILED at %0t ns: %0d stores seen, expected %0d",
                     $time, n_stores, exp_addr.size());
        end

        $display("Checks: %0d, errors: %0d, stores: %0d", n_checks, n_errors, n_stores);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog scaled to the program length
    initial begin
        wait (prog_len > 0);
        #((prog_len * 2 + 50) * CLK_PERIOD);
        n_errors++;
        $display("Timeout: the run did not finish within %0d ns",
                 (prog_len * 2 + 50) * CLK_PERIOD);
        $display("Checks: %0d, errors: %0d, stores: %0d", n_checks, n_errors, n_stores);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/mips_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/openmips.sv
bench/openmips_chk.sv
bench/tb_openmips.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_openmips -Mdir obj_dir -o sim
./obj_dir/sim 2>&1 | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation ended without a pass result"
    exit 1
fi
echo "Simulation passed"
